// ==== src/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 64
`define STRB_WIDTH 8

// slave windows behind the decoder
`define NUM_WINDOWS 3

`define RAM_BASE  32'h1c00_0000
`define VGA_BASE  32'h0001_0000
`define PERI_BASE 32'h0002_0000

// low address bits covered by each window
`define RAM_LEN_BITS  16
`define VGA_LEN_BITS  11
`define PERI_LEN_BITS 16

// word index is addr[10:3], so the larger windows alias every 2 KiB
`define BANK_INDEX_BITS 8
`define BANK_WORDS      256

`endif

// ==== src/axi_pkg.sv ====
`include "soc_config.svh"

package axi_pkg;

   // only the two codes this fabric can return
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_DECERR = 2'b11
   } resp_t;

   // one bus word, viewed flat or as byte lanes
   typedef union packed {
      logic [`DATA_WIDTH-1:0]      word;
      logic [`STRB_WIDTH-1:0][7:0] byte_lane;
   } data_word_u;

endpackage

// ==== src/soc_map_pkg.sv ====
`include "soc_config.svh"

package soc_map_pkg;

   // window codes double as bank numbers
   // WIN_NONE marks an unmapped address
   typedef enum logic [1:0] {
      WIN_RAM  = 2'd0,
      WIN_VGA  = 2'd1,
      WIN_PERI = 2'd2,
      WIN_NONE = 2'd3
   } window_t;

   // word index within one bank
   typedef logic [`BANK_INDEX_BITS-1:0] bank_index_t;

endpackage

// ==== src/axi_addr_decoder.sv ====
`timescale 1ns/1ns
`include "soc_config.svh"

module axi_addr_decoder (
   input  logic [`ADDR_WIDTH-1:0]  awaddr,
   input  logic                    awvalid,
   input  axi_pkg::data_word_u     wdata,
   input  logic [`STRB_WIDTH-1:0]  wstrb,
   input  logic                    wvalid,
   input  logic [`ADDR_WIDTH-1:0]  araddr,
   input  logic                    arvalid,
   input  logic                    wr_busy,
   input  logic                    rd_busy,
   output logic                    awready,
   output logic                    wready,
   output logic                    arready,
   output logic [`NUM_WINDOWS-1:0] bank_wr_en,
   output logic [`NUM_WINDOWS-1:0] bank_rd_en,
   output soc_map_pkg::bank_index_t wr_index,
   output soc_map_pkg::bank_index_t rd_index,
   output axi_pkg::data_word_u     bank_wdata,
   output logic [`STRB_WIDTH-1:0]  bank_wstrb,
   output logic                    wr_accept,
   output soc_map_pkg::window_t    wr_window,
   output logic                    rd_accept,
   output soc_map_pkg::window_t    rd_window
);

   // byte offset bits below the word index
   localparam int OFFSET_BITS = $clog2(`STRB_WIDTH);

   function automatic soc_map_pkg::window_t match_window(input logic [`ADDR_WIDTH-1:0] addr);
      soc_map_pkg::window_t win;
      win = soc_map_pkg::WIN_NONE;
      if ((addr >> `RAM_LEN_BITS) == (`RAM_BASE >> `RAM_LEN_BITS))
         win = soc_map_pkg::WIN_RAM;
      else if ((addr >> `VGA_LEN_BITS) == (`VGA_BASE >> `VGA_LEN_BITS))
         win = soc_map_pkg::WIN_VGA;
      else if ((addr >> `PERI_LEN_BITS) == (`PERI_BASE >> `PERI_LEN_BITS))
         win = soc_map_pkg::WIN_PERI;
      return win;
   endfunction

   // one transfer in flight per direction
   assign awready = !wr_busy;
   assign wready  = !wr_busy;
   assign arready = !rd_busy;

   // address and data are taken together
   assign wr_accept = awvalid && wvalid && !wr_busy;
   assign rd_accept = arvalid && !rd_busy;

   assign wr_window = match_window(awaddr);
   assign rd_window = match_window(araddr);

   assign wr_index = awaddr[`BANK_INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS];
   assign rd_index = araddr[`BANK_INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS];

   assign bank_wdata = wdata;
   assign bank_wstrb = wstrb;

   // unmapped requests leave every bank idle
   always_comb
   begin
      bank_wr_en = '0;
      bank_rd_en = '0;
      for (int i = 0; i < `NUM_WINDOWS; i++)
      begin
         bank_wr_en[i] = wr_accept && (wr_window == soc_map_pkg::window_t'(i));
         bank_rd_en[i] = rd_accept && (rd_window == soc_map_pkg::window_t'(i));
      end
   end

endmodule

// ==== src/sram_bank.sv ====
`timescale 1ns/1ns
`include "soc_config.svh"

module sram_bank (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     wr_en,
   input  soc_map_pkg::bank_index_t wr_index,
   input  axi_pkg::data_word_u      wr_data,
   input  logic [`STRB_WIDTH-1:0]   wr_strb,
   input  logic                     rd_en,
   input  soc_map_pkg::bank_index_t rd_index,
   output axi_pkg::data_word_u      rd_data
);

   axi_pkg::data_word_u mem [`BANK_WORDS];

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         for (int i = 0; i < `BANK_WORDS; i++)
         begin
            mem[i] <= '0;
         end
         rd_data <= '0;
      end
      else
      begin
         // merge only the strobed lanes
         if (wr_en)
         begin
            for (int b = 0; b < `STRB_WIDTH; b++)
            begin
               if (wr_strb[b])
                  mem[wr_index].byte_lane[b] <= wr_data.byte_lane[b];
            end
         end
         // old word on a same-edge collision
         if (rd_en)
            rd_data <= mem[rd_index];
      end
   end

endmodule

// ==== src/axi_resp_mux.sv ====
`timescale 1ns/1ns
`include "soc_config.svh"

module axi_resp_mux (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic                                       wr_accept,
   input  soc_map_pkg::window_t                       wr_window,
   input  logic                                       rd_accept,
   input  soc_map_pkg::window_t                       rd_window,
   input  axi_pkg::data_word_u [`NUM_WINDOWS-1:0]     bank_rdata,
   input  logic                                       bready,
   input  logic                                       rready,
   output axi_pkg::resp_t                             bresp,
   output logic                                       bvalid,
   output axi_pkg::resp_t                             rresp,
   output logic                                       rvalid,
   output axi_pkg::data_word_u                        rdata,
   output logic                                       wr_busy,
   output logic                                       rd_busy
);

   // window of the read in flight
   soc_map_pkg::window_t rd_sel;

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end
      else
      begin
         if (wr_accept)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;

         if (rd_accept)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // response codes and read window held until the next accept
   always_ff @(posedge clk)
   begin
      if (wr_accept)
      begin
         if (wr_window == soc_map_pkg::WIN_NONE)
            bresp <= axi_pkg::RESP_DECERR;
         else
            bresp <= axi_pkg::RESP_OKAY;
      end
      if (rd_accept)
      begin
         rd_sel <= rd_window;
         if (rd_window == soc_map_pkg::WIN_NONE)
            rresp <= axi_pkg::RESP_DECERR;
         else
            rresp <= axi_pkg::RESP_OKAY;
      end
   end

   // bank output stays put until its next rd_en, so this is stable under stall
   always_comb
   begin
      rdata = '0;
      if (rd_sel != soc_map_pkg::WIN_NONE)
         rdata = bank_rdata[rd_sel];
   end

   assign wr_busy = bvalid;
   assign rd_busy = rvalid;

endmodule

// ==== src/axi_soc_fabric.sv ====
`timescale 1ns/1ns
`include "soc_config.svh"

module axi_soc_fabric (
   input  logic                   clk,
   input  logic                   resetn,
   input  logic [`ADDR_WIDTH-1:0] awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  axi_pkg::data_word_u    wdata,
   input  logic [`STRB_WIDTH-1:0] wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output axi_pkg::resp_t         bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [`ADDR_WIDTH-1:0] araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output axi_pkg::data_word_u    rdata,
   output axi_pkg::resp_t         rresp,
   output logic                   rvalid,
   input  logic                   rready
);

   logic                                   wr_busy;
   logic                                   rd_busy;
   logic [`NUM_WINDOWS-1:0]                bank_wr_en;
   logic [`NUM_WINDOWS-1:0]                bank_rd_en;
   soc_map_pkg::bank_index_t               wr_index;
   soc_map_pkg::bank_index_t               rd_index;
   axi_pkg::data_word_u                    bank_wdata;
   logic [`STRB_WIDTH-1:0]                 bank_wstrb;
   logic                                   wr_accept;
   soc_map_pkg::window_t                   wr_window;
   logic                                   rd_accept;
   soc_map_pkg::window_t                   rd_window;
   axi_pkg::data_word_u [`NUM_WINDOWS-1:0] bank_rdata;

   axi_addr_decoder u_decoder (
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .wr_busy    (wr_busy),
      .rd_busy    (rd_busy),
      .awready    (awready),
      .wready     (wready),
      .arready    (arready),
      .bank_wr_en (bank_wr_en),
      .bank_rd_en (bank_rd_en),
      .wr_index   (wr_index),
      .rd_index   (rd_index),
      .bank_wdata (bank_wdata),
      .bank_wstrb (bank_wstrb),
      .wr_accept  (wr_accept),
      .wr_window  (wr_window),
      .rd_accept  (rd_accept),
      .rd_window  (rd_window)
   );

   // bank g serves window code g
   genvar g;
   generate
      for (g = 0; g < `NUM_WINDOWS; g++)
      begin : g_bank
         sram_bank u_bank (
            .clk      (clk),
            .resetn   (resetn),
            .wr_en    (bank_wr_en[g]),
            .wr_index (wr_index),
            .wr_data  (bank_wdata),
            .wr_strb  (bank_wstrb),
            .rd_en    (bank_rd_en[g]),
            .rd_index (rd_index),
            .rd_data  (bank_rdata[g])
         );
      end
   endgenerate

   axi_resp_mux u_resp_mux (
      .clk        (clk),
      .resetn     (resetn),
      .wr_accept  (wr_accept),
      .wr_window  (wr_window),
      .rd_accept  (rd_accept),
      .rd_window  (rd_window),
      .bank_rdata (bank_rdata),
      .bready     (bready),
      .rready     (rready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rdata      (rdata),
      .wr_busy    (wr_busy),
      .rd_busy    (rd_busy)
   );

endmodule

// ==== verification/axi_soc_fabric_tb.sv ====
`timescale 1ns/1ns
`include "soc_config.svh"

module axi_soc_fabric_tb;

   localparam int NUM_TESTS = 6;

   logic                   clk;
   logic                   resetn;
   logic [`ADDR_WIDTH-1:0] awaddr;
   logic                   awvalid;
   logic                   awready;
   axi_pkg::data_word_u    wdata;
   logic [`STRB_WIDTH-1:0] wstrb;
   logic                   wvalid;
   logic                   wready;
   axi_pkg::resp_t         bresp;
   logic                   bvalid;
   logic                   bready;
   logic [`ADDR_WIDTH-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   axi_pkg::data_word_u    rdata;
   axi_pkg::resp_t         rresp;
   logic                   rvalid;
   logic                   rready;

   int errors = 0;
   int failed_tests = 0;
   logic [63:0] model [int];

   // previous-cycle samples for the protocol checks
   logic        p_resetn = 1'b0;
   logic        p_bvalid;
   logic        p_bready;
   logic        p_rvalid;
   logic        p_rready;
   logic        p_wacc;
   logic        p_racc;
   logic [1:0]  p_bresp;
   logic [1:0]  p_rresp;
   logic [63:0] p_rdata;

   axi_soc_fabric dut0 (
      .clk(clk), .resetn(resetn),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   always #20 clk = ~clk;

   // window code from the memory map, -1 when unmapped
   function automatic int window_of(input logic [31:0] addr);
      if (addr[31:16] == 16'h1c00)
         return 0;
      if (addr[31:11] == (32'h0001_0000 >> 11))
         return 1;
      if (addr[31:16] == 16'h0002)
         return 2;
      return -1;
   endfunction

   function automatic int model_key(input logic [31:0] addr);
      return window_of(addr) * 256 + int'(addr[10:3]);
   endfunction

   function automatic logic [31:0] random_addr(input int win);
      logic [31:0] r;
      r = $urandom;
      case (win)
         0: return 32'h1c00_0000 | (r & 32'h0000_fff8);
         1: return 32'h0001_0000 | (r & 32'h0000_07f8);
         2: return 32'h0002_0000 | (r & 32'h0000_fff8);
         default: return 32'h3000_0000 | (r & 32'h00ff_fff8);
      endcase
   endfunction

   function automatic logic [63:0] expected_word(input logic [31:0] addr);
      if (window_of(addr) < 0)
         return 64'h0;
      if (model.exists(model_key(addr)))
         return model[model_key(addr)];
      return 64'h0;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
      assert (exp === act)
      else
      begin
         $display("FAILED %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic protocol_error(input string what);
      $display("protocol error at %0t ns: %s", $time, what);
      errors++;
   endtask

   // called 2 ns after a rising edge
   task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input int stall);
      logic [63:0] merged;
      awaddr = addr;
      wdata.word = data;
      wstrb = strb;
      awvalid = 1'b1;
      wvalid = 1'b1;
      @(negedge clk);
      while (!(awready && wready))
         @(negedge clk);
      @(posedge clk);
      #2;
      awvalid = 1'b0;
      wvalid = 1'b0;
      // bus lines are free once the request is taken
      awaddr = ~addr;
      wdata.word = ~data;
      if (window_of(addr) >= 0)
      begin
         merged = expected_word(addr);
         for (int b = 0; b < 8; b++)
            if (strb[b])
               merged[b*8 +: 8] = data[b*8 +: 8];
         model[model_key(addr)] = merged;
      end
      @(negedge clk);
      while (!bvalid)
         @(negedge clk);
      compare_value("bresp", (window_of(addr) < 0) ? 64'h3 : 64'h0, 64'(bresp));
      repeat (stall)
         @(posedge clk);
      @(posedge clk);
      #2 bready = 1'b1;
      @(posedge clk);
      #2 bready = 1'b0;
   endtask

   task automatic read_word(input logic [31:0] addr, input int stall);
      araddr = addr;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready)
         @(negedge clk);
      @(posedge clk);
      #2 arvalid = 1'b0;
      araddr = ~addr;
      @(negedge clk);
      while (!rvalid)
         @(negedge clk);
      compare_value("rresp", (window_of(addr) < 0) ? 64'h3 : 64'h0, 64'(rresp));
      compare_value("rdata", expected_word(addr), rdata.word);
      repeat (stall)
         @(posedge clk);
      @(posedge clk);
      #2 rready = 1'b1;
      @(posedge clk);
      #2 rready = 1'b0;
   endtask

   task automatic finish_test(input int num, input string name, input int errors_before);
      if (errors != errors_before)
         failed_tests++;
      $display("test %0d %s: %s", num, name, (errors == errors_before) ? "ok" : "failed");
   endtask

   // valid/data stability and one-cycle response latency
   always @(negedge clk)
   begin
      if (resetn && p_resetn)
      begin
         if (p_bvalid && !p_bready)
            assert (bvalid && bresp == p_bresp)
            else protocol_error("write response changed while bready was low");
         if (p_rvalid && !p_rready)
            assert (rvalid && rresp == p_rresp && rdata.word == p_rdata)
            else protocol_error("read response changed while rready was low");
         assert (bvalid == (p_wacc || (p_bvalid && !p_bready)))
         else protocol_error("bvalid did not rise exactly one cycle after write accept");
         assert (rvalid == (p_racc || (p_rvalid && !p_rready)))
         else protocol_error("rvalid did not rise exactly one cycle after read accept");
         assert (awready == !bvalid && wready == !bvalid)
         else protocol_error("write channel ready does not follow the pending response");
         assert (arready == !rvalid)
         else protocol_error("read channel ready does not follow the pending response");
      end
      p_resetn <= resetn;
      p_bvalid <= bvalid;
      p_bready <= bready;
      p_bresp  <= bresp;
      p_rvalid <= rvalid;
      p_rready <= rready;
      p_rresp  <= rresp;
      p_rdata  <= rdata.word;
      p_wacc   <= awvalid && wvalid && awready && wready;
      p_racc   <= arvalid && arready;
   end

   initial
   begin
      #(NUM_TESTS * 200 * 40);
      $display("watchdog expired, the DUT stopped responding");
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      logic [31:0] a [3];
      logic [31:0] bad;
      int e;
      void'($urandom(32'hda6c_b0e7));
      clk = 1'b0;
      resetn = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      repeat (2)
         @(posedge clk);
      #2 resetn = 1'b1;

      e = errors;
      @(negedge clk);
      assert (!bvalid && !rvalid && awready && wready && arready)
      else protocol_error("valids or readies wrong after reset");
      @(posedge clk);
      #2;
      // banks come out of reset cleared
      read_word(random_addr(1), 0);
      finish_test(6, "reset state", e);

      e = errors;
      for (int w = 0; w < 3; w++)
      begin
         a[w] = random_addr(w);
         write_word(a[w], {$urandom, $urandom}, 8'hff, 0);
         read_word(a[w], 0);
      end
      finish_test(1, "full write and read per window", e);

      e = errors;
      for (int w = 0; w < 3; w++)
      begin
         write_word(a[w], {$urandom, $urandom}, 8'h5a ^ 8'(w), 0);
         read_word(a[w], 0);
      end
      finish_test(2, "partial strobe merge", e);

      e = errors;
      bad = random_addr(-1);
      // same word index as each written word
      for (int w = 0; w < 3; w++)
         write_word((bad & ~32'h7f8) | (a[w] & 32'h7f8), {$urandom, $urandom}, 8'hff, 0);
      read_word(bad, 0);
      for (int w = 0; w < 3; w++)
         read_word(a[w], 0);
      finish_test(3, "unmapped address", e);

      e = errors;
      read_word(a[0] ^ 32'h0000_0800, 0);
      read_word(a[2] ^ 32'h0000_0800, 0);
      write_word(32'h0001_0000 | (a[0] & 32'h7f8), {$urandom, $urandom}, 8'hff, 0);
      read_word(32'h1c00_0000 | (a[0] & 32'h7f8), 0);
      finish_test(4, "aliasing and window separation", e);

      e = errors;
      write_word(random_addr(0), {$urandom, $urandom}, 8'hff, 4);
      read_word(a[1], 5);
      read_word(bad, 3);
      finish_test(5, "ready back-pressure", e);

      $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+src
src/axi_pkg.sv
src/soc_map_pkg.sv
src/axi_addr_decoder.sv
src/sram_bank.sv
src/axi_resp_mux.sv
src/axi_soc_fabric.sv
verification/axi_soc_fabric_tb.sv

// ==== Bender.yml ====
package:
  name: axi_soc_fabric

sources:
  - include_dirs:
      - src
    files:
      - src/axi_pkg.sv
      - src/soc_map_pkg.sv
      - src/axi_addr_decoder.sv
      - src/sram_bank.sv
      - src/axi_resp_mux.sv
      - src/axi_soc_fabric.sv

  - target: test
    include_dirs:
      - src
    files:
      - verification/axi_soc_fabric_tb.sv
